//--- lms_frontend_asserts.sv
`timescale 1ns/1ns

module lms_frontend_asserts
(
   input logic lms_clk,
   input logic rst_i,
   input logic rx1_valid_i,
   input logic rx2_valid_i,
   input logic tx1_iqsel_i,
   input logic tx2_iqsel_i,
   input logic tx_load_i
);

   int fail_cnt = 0;   // Read by the testbench for the closing report

   // A pair needs an I edge and a Q edge, so strobes never touch
   rx1_gap_a: assert property (@(posedge lms_clk) disable iff (rst_i)
                               rx1_valid_i |=> !rx1_valid_i)
   else
   begin
      $error("rx1_valid_o was high on two consecutive cycles");
      fail_cnt++;
   end

   rx2_gap_a: assert property (@(posedge lms_clk) disable iff (rst_i)
                               rx2_valid_i |=> !rx2_valid_i)
   else
   begin
      $error("rx2_valid_o was high on two consecutive cycles");
      fail_cnt++;
   end

   tx_load_toggle_a: assert property (@(posedge lms_clk) disable iff (rst_i)
                                      1'b1 |=> (tx_load_i != $past(tx_load_i)))
   else
   begin
      $error("tx_load_o stopped alternating");
      fail_cnt++;
   end

   // First cycle out of reset still shows the reset state
   tx_iqsel_a: assert property (@(posedge lms_clk) disable iff (rst_i)
                                !$past(rst_i) |-> (tx1_iqsel_i == !tx_load_i)
                                                  && (tx2_iqsel_i == !tx_load_i))
   else
   begin
      $error("tx IQ select was not low exactly on the load cycles");
      fail_cnt++;
   end

endmodule

//--- lms_frontend_cfg.svh
`ifndef LMS_FRONTEND_CFG_SVH
`define LMS_FRONTEND_CFG_SVH

// LMS6002D converter word on the parallel RX and TX buses
`define LMS_SAMPLE_W 12

// Receive sample width expected by the baseband core
`define CORE_SAMPLE_W 14

// Zero bits below the LMS word when widening to core format.
// LMS_SAMPLE_W + CORE_PAD_W must equal CORE_SAMPLE_W
`define CORE_PAD_W 2

// Transceivers on the board
`define NUM_LMS 2

`endif

//--- lms_frontend_checker.sv
`timescale 1ns/1ns
`include "lms_frontend_cfg.svh"

module lms_frontend_checker
   import lms_frontend_pkg::*;
(
   input  logic         lms_clk,
   input  logic         rst_i,
   input  lms_word_t    rx1_d_i, rx2_d_i,
   input  logic         rx1_iqsel_i, rx2_iqsel_i,
   input  core_sample_t rx1_isamp_i, rx1_qsamp_i, rx2_isamp_i, rx2_qsamp_i,
   input  logic         rx1_valid_i, rx2_valid_i,
   input  lms_word_t    dac1_i_i, dac1_q_i, dac2_i_i, dac2_q_i,
   input  lms_word_t    tx1_d_i, tx2_d_i,
   input  logic         tx1_iqsel_i, tx2_iqsel_i, tx_load_i,
   input  logic         spi_sclk_i, spi_mosi_i, spi_miso_i,
   input  logic         sen_lms1_i, sen_lms2_i, sen_dac_i,
   input  logic         lms1_miso_i, lms2_miso_i,
   input  logic         lms1_sclk_i, lms1_mosi_i, lms1_sen_i,
   input  logic         lms2_sclk_i, lms2_mosi_i, lms2_sen_i,
   input  logic         dac_sclk_i, dac_mosi_i, dac_sen_i,
   output int           rx_err_o,
   output int           tx_err_o,
   output int           spi_err_o,
   output int           pair_cnt_o
);

   logic         armed;                  // Model is meaningful after a reset edge
   logic         pend_v [`NUM_LMS];
   lms_word_t    pend_i [`NUM_LMS];
   logic         due_v [`NUM_LMS];       // Pair seen, core outputs take it next edge
   lms_word_t    due_i [`NUM_LMS];
   lms_word_t    due_q [`NUM_LMS];
   logic         exp_v [`NUM_LMS];
   core_sample_t exp_i [`NUM_LMS];
   core_sample_t exp_q [`NUM_LMS];
   logic         phase;
   lms_word_t    q_lat [`NUM_LMS];
   lms_word_t    exp_d [`NUM_LMS];
   logic         exp_iqsel;
   logic         exp_load;

   // Core format is the LMS word scaled by four
   function automatic core_sample_t widen(input lms_word_t w);
      return core_sample_t'(w) << `CORE_PAD_W;
   endfunction

   function automatic logic gated(input logic sen_n, input logic v);
      return !sen_n && v;
   endfunction

   function automatic logic miso_ref(input logic s1_n, input logic s2_n,
                                     input logic m1, input logic m2);
      return gated(s1_n, m1) || gated(s2_n, m2);
   endfunction

   task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act,
                        inout int cnt);
      if (act !== exp)
      begin
         $display("[ERROR] %0t ns %s expected %0h actual %0h", $time, name, exp, act);
         cnt++;
      end
   endtask

   // Compare one receive channel, then advance its pairing state
   task automatic rx_step(input int n, input lms_word_t d, input logic iqsel,
                          input core_sample_t act_i, input core_sample_t act_q,
                          input logic act_v);
      check($sformatf("rx%0d_valid_o", n + 1), exp_v[n], act_v, rx_err_o);
      check($sformatf("rx%0d_i_o", n + 1), exp_i[n], act_i, rx_err_o);
      check($sformatf("rx%0d_q_o", n + 1), exp_q[n], act_q, rx_err_o);
      if (act_v === 1'b1)
         pair_cnt_o++;
      exp_v[n] = due_v[n];
      if (due_v[n])
      begin
         exp_i[n] = widen(due_i[n]);
         exp_q[n] = widen(due_q[n]);
      end
      due_v[n] = !iqsel && pend_v[n];   // Orphan Q gives nothing
      due_i[n] = pend_i[n];
      due_q[n] = d;
      if (iqsel)
      begin
         pend_v[n] = 1'b1;
         pend_i[n] = d;                 // Latest I wins
      end
      else
         pend_v[n] = 1'b0;
   endtask

   task automatic tx_step();
      check("tx_load_o", exp_load, tx_load_i, tx_err_o);
      check("tx1_iqsel_o", exp_iqsel, tx1_iqsel_i, tx_err_o);
      check("tx2_iqsel_o", exp_iqsel, tx2_iqsel_i, tx_err_o);
      check("tx1_d_o", exp_d[0], tx1_d_i, tx_err_o);
      check("tx2_d_o", exp_d[1], tx2_d_i, tx_err_o);
      exp_load  = !phase;
      exp_iqsel = phase;
      if (!phase)
      begin
         exp_d[0] = dac1_i_i;
         exp_d[1] = dac2_i_i;
         q_lat[0] = dac1_q_i;
         q_lat[1] = dac2_q_i;
      end
      else
      begin
         exp_d[0] = q_lat[0];
         exp_d[1] = q_lat[1];
      end
      phase = !phase;
   endtask

   task automatic reset_model();
      for (int n = 0; n < `NUM_LMS; n++)
      begin
         pend_v[n] = 1'b0;
         due_v[n]  = 1'b0;
         exp_v[n]  = 1'b0;
         exp_i[n]  = '0;
         exp_q[n]  = '0;
         exp_d[n]  = '0;
      end
      phase     = 1'b0;
      exp_load  = 1'b0;
      exp_iqsel = 1'b0;
      armed     = 1'b1;
   endtask

   initial
   begin
      armed      = 1'b0;
      rx_err_o   = 0;
      tx_err_o   = 0;
      spi_err_o  = 0;
      pair_cnt_o = 0;
   end

   // Outputs read here still carry the result of the previous edge
   always @(posedge lms_clk)
   begin
      check("lms1_sclk_o", gated(sen_lms1_i, spi_sclk_i), lms1_sclk_i, spi_err_o);
      check("lms1_mosi_o", gated(sen_lms1_i, spi_mosi_i), lms1_mosi_i, spi_err_o);
      check("lms2_sclk_o", gated(sen_lms2_i, spi_sclk_i), lms2_sclk_i, spi_err_o);
      check("lms2_mosi_o", gated(sen_lms2_i, spi_mosi_i), lms2_mosi_i, spi_err_o);
      check("dac_sclk_o", gated(sen_dac_i, spi_sclk_i), dac_sclk_i, spi_err_o);
      check("dac_mosi_o", gated(sen_dac_i, spi_mosi_i), dac_mosi_i, spi_err_o);
      check("spi_miso_o", miso_ref(sen_lms1_i, sen_lms2_i, lms1_miso_i, lms2_miso_i),
            spi_miso_i, spi_err_o);
      check("lms1_sen_o", sen_lms1_i, lms1_sen_i, spi_err_o);
      check("lms2_sen_o", sen_lms2_i, lms2_sen_i, spi_err_o);
      check("dac_sen_o", sen_dac_i, dac_sen_i, spi_err_o);
      if (armed)
      begin
         rx_step(0, rx1_d_i, rx1_iqsel_i, rx1_isamp_i, rx1_qsamp_i, rx1_valid_i);
         rx_step(1, rx2_d_i, rx2_iqsel_i, rx2_isamp_i, rx2_qsamp_i, rx2_valid_i);
         tx_step();
      end
      if (rst_i)
         reset_model();
   end

endmodule

//--- lms_frontend_pkg.sv
`include "lms_frontend_cfg.svh"

package lms_frontend_pkg;

   // One word on an LMS RX or TX data bus
   typedef logic [`LMS_SAMPLE_W-1:0] lms_word_t;

   // One receive sample as seen by the core
   typedef logic [`CORE_SAMPLE_W-1:0] core_sample_t;

   // LMS word into the MSBs of a core sample, zeros below
   function automatic core_sample_t lms_to_core(input lms_word_t w);
      core_sample_t s;
      s = {w, {`CORE_PAD_W{1'b0}}};
      return s;
   endfunction

endpackage

//--- lms_frontend_tb.sv
`timescale 1ns/1ns
`include "lms_frontend_cfg.svh"

module lms_frontend_tb
   import lms_frontend_pkg::*;
();

   localparam int CLK_PERIOD  = 100;
   localparam int RST_CYCLES  = 8;
   localparam int RX_ALT_CYC  = 300;   // Regular I/Q alternation
   localparam int RX_IRR_CYC  = 300;   // Random selects with repeats and orphans
   localparam int STIM_CYCLES = RST_CYCLES + RX_ALT_CYC + RX_IRR_CYC + 4;
   localparam int WDOG_CYCLES = STIM_CYCLES + 50;

   logic         lms_clk, rst_i;
   lms_word_t    rx1_d_i, rx2_d_i;
   logic         rx1_iqsel_i, rx2_iqsel_i;
   core_sample_t rx1_i_o, rx1_q_o, rx2_i_o, rx2_q_o;
   logic         rx1_valid_o, rx2_valid_o;
   lms_word_t    dac1_i_i, dac1_q_i, dac2_i_i, dac2_q_i;
   lms_word_t    tx1_d_o, tx2_d_o;
   logic         tx1_iqsel_o, tx2_iqsel_o, tx_load_o;
   logic         spi_sclk_i, spi_mosi_i, spi_miso_o;
   logic         sen_lms1_i, sen_lms2_i, sen_dac_i;
   logic         lms1_miso_i, lms2_miso_i;
   logic         lms1_sclk_o, lms1_mosi_o, lms1_sen_o;
   logic         lms2_sclk_o, lms2_mosi_o, lms2_sen_o;
   logic         dac_sclk_o, dac_mosi_o, dac_sen_o;
   int           rx_errs, tx_errs, spi_errs, pair_cnt, other_errs;
   logic [15:0]  lfsr_state;

   lms_frontend_top lms_frontend_top_i (.*);

   lms_frontend_checker lms_frontend_checker_i
   (
      .rx1_isamp_i (rx1_i_o),
      .rx1_qsamp_i (rx1_q_o),
      .rx1_valid_i (rx1_valid_o),
      .rx2_isamp_i (rx2_i_o),
      .rx2_qsamp_i (rx2_q_o),
      .rx2_valid_i (rx2_valid_o),
      .tx1_d_i     (tx1_d_o),
      .tx2_d_i     (tx2_d_o),
      .tx1_iqsel_i (tx1_iqsel_o),
      .tx2_iqsel_i (tx2_iqsel_o),
      .tx_load_i   (tx_load_o),
      .spi_miso_i  (spi_miso_o),
      .lms1_sclk_i (lms1_sclk_o),
      .lms1_mosi_i (lms1_mosi_o),
      .lms1_sen_i  (lms1_sen_o),
      .lms2_sclk_i (lms2_sclk_o),
      .lms2_mosi_i (lms2_mosi_o),
      .lms2_sen_i  (lms2_sen_o),
      .dac_sclk_i  (dac_sclk_o),
      .dac_mosi_i  (dac_mosi_o),
      .dac_sen_i   (dac_sen_o),
      .rx_err_o    (rx_errs),
      .tx_err_o    (tx_errs),
      .spi_err_o   (spi_errs),
      .pair_cnt_o  (pair_cnt),
      .*
   );

   bind lms_frontend_top lms_frontend_asserts asserts_i
   (
      .lms_clk     (lms_clk),
      .rst_i       (rst_i),
      .rx1_valid_i (rx1_valid_o),
      .rx2_valid_i (rx2_valid_o),
      .tx1_iqsel_i (tx1_iqsel_o),
      .tx2_iqsel_i (tx2_iqsel_o),
      .tx_load_i   (tx_load_o)
   );

   always #(CLK_PERIOD / 2) lms_clk = ~lms_clk;

   // Galois form with taps for x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   task automatic take_bits(input int nbits, output logic [31:0] v);
      v = '0;
      for (int b = 0; b < nbits; b++)
      begin
         v          = {v[30:0], lfsr_state[0]};
         lfsr_state = lfsr_step(lfsr_state);   // One step per bit
      end
   endtask

   task automatic rand_word(output lms_word_t w);
      logic [31:0] v;
      take_bits(`LMS_SAMPLE_W, v);
      w = v[`LMS_SAMPLE_W-1:0];
   endtask

   // New DAC words every cycle, so the Q edge sees words other than the held pair
   task automatic drive_cycle(input logic sel1, input logic sel2);
      logic [31:0] v;
      rx1_iqsel_i = sel1;
      rx2_iqsel_i = sel2;
      rand_word(rx1_d_i);
      rand_word(rx2_d_i);
      rand_word(dac1_i_i);
      rand_word(dac1_q_i);
      rand_word(dac2_i_i);
      rand_word(dac2_q_i);
      take_bits(7, v);
      {spi_sclk_i, spi_mosi_i, lms1_miso_i, lms2_miso_i} = v[3:0];
      {sen_lms1_i, sen_lms2_i, sen_dac_i} = v[6:4];
   endtask

   initial
   begin
      logic [31:0] sel;
      lfsr_state  = 16'd17;
      other_errs  = 0;
      lms_clk     = 1'b0;
      rst_i       = 1'b1;
      {rx1_d_i, rx2_d_i, rx1_iqsel_i, rx2_iqsel_i} = '0;
      {dac1_i_i, dac1_q_i, dac2_i_i, dac2_q_i}     = '0;
      {spi_sclk_i, spi_mosi_i, lms1_miso_i, lms2_miso_i} = '0;
      {sen_lms1_i, sen_lms2_i, sen_dac_i} = 3'b111;   // All devices idle
      repeat (RST_CYCLES) @(negedge lms_clk);
      rst_i = 1'b0;
      for (int k = 0; k < RX_ALT_CYC; k++)
      begin
         drive_cycle(k[0] == 1'b0, k[0] == 1'b1);   // Channel 2 opens with an orphan Q
         @(negedge lms_clk);
      end
      for (int k = 0; k < RX_IRR_CYC; k++)
      begin
         take_bits(2, sel);
         drive_cycle(sel[1], sel[0]);
         @(negedge lms_clk);
      end
      repeat (4) @(negedge lms_clk);
      if (pair_cnt == 0)
      begin
         $display("No receive pair reached the core outputs during the run");
         other_errs++;
      end
      $display("Error counts: rx %0d, tx %0d, spi %0d, assert %0d, other %0d",
               rx_errs, tx_errs, spi_errs, lms_frontend_top_i.asserts_i.fail_cnt, other_errs);
      if (rx_errs + tx_errs + spi_errs + lms_frontend_top_i.asserts_i.fail_cnt
          + other_errs == 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   end

   initial
   begin
      #(WDOG_CYCLES * CLK_PERIOD);
      $display("Watchdog fired, stimulus did not finish within %0d cycles", WDOG_CYCLES);
      $display("CHECKS FAILED");
      $finish;
   end

endmodule

//--- lms_frontend_top.sv
`timescale 1ns/1ns

module lms_frontend_top
   import lms_frontend_pkg::*;
(
   input  logic         lms_clk,
   input  logic         rst_i,

   // LMS receive buses
   input  lms_word_t    rx1_d_i,
   input  logic         rx1_iqsel_i,
   input  lms_word_t    rx2_d_i,
   input  logic         rx2_iqsel_i,

   // Receive samples to the core
   output core_sample_t rx1_i_o,
   output core_sample_t rx1_q_o,
   output logic         rx1_valid_o,
   output core_sample_t rx2_i_o,
   output core_sample_t rx2_q_o,
   output logic         rx2_valid_o,

   // Transmit words from the core
   input  lms_word_t    dac1_i_i,
   input  lms_word_t    dac1_q_i,
   input  lms_word_t    dac2_i_i,
   input  lms_word_t    dac2_q_i,

   // LMS transmit buses
   output lms_word_t    tx1_d_o,
   output lms_word_t    tx2_d_o,
   output logic         tx1_iqsel_o,
   output logic         tx2_iqsel_o,
   output logic         tx_load_o,

   // SPI master side
   input  logic         spi_sclk_i,
   input  logic         spi_mosi_i,
   input  logic         sen_lms1_i,
   input  logic         sen_lms2_i,
   input  logic         sen_dac_i,
   output logic         spi_miso_o,

   // SPI device side
   input  logic         lms1_miso_i,
   input  logic         lms2_miso_i,
   output logic         lms1_sclk_o,
   output logic         lms1_mosi_o,
   output logic         lms1_sen_o,
   output logic         lms2_sclk_o,
   output logic         lms2_mosi_o,
   output logic         lms2_sen_o,
   output logic         dac_sclk_o,
   output logic         dac_mosi_o,
   output logic         dac_sen_o
);

   lms_rx_deinterleave lms_rx_deinterleave_i
   (
      .lms_clk     (lms_clk),
      .rst_i       (rst_i),
      .rx1_d_i     (rx1_d_i),
      .rx1_iqsel_i (rx1_iqsel_i),
      .rx2_d_i     (rx2_d_i),
      .rx2_iqsel_i (rx2_iqsel_i),
      .rx1_i_o     (rx1_i_o),
      .rx1_q_o     (rx1_q_o),
      .rx1_valid_o (rx1_valid_o),
      .rx2_i_o     (rx2_i_o),
      .rx2_q_o     (rx2_q_o),
      .rx2_valid_o (rx2_valid_o)
   );

   lms_tx_interleave lms_tx_interleave_i
   (
      .lms_clk     (lms_clk),
      .rst_i       (rst_i),
      .dac1_i_i    (dac1_i_i),
      .dac1_q_i    (dac1_q_i),
      .dac2_i_i    (dac2_i_i),
      .dac2_q_i    (dac2_q_i),
      .tx1_d_o     (tx1_d_o),
      .tx2_d_o     (tx2_d_o),
      .tx1_iqsel_o (tx1_iqsel_o),
      .tx2_iqsel_o (tx2_iqsel_o),
      .tx_load_o   (tx_load_o)
   );

   // Purely combinational, reset plays no part
   lms_spi_router lms_spi_router_i
   (
      .spi_sclk_i  (spi_sclk_i),
      .spi_mosi_i  (spi_mosi_i),
      .spi_miso_o  (spi_miso_o),
      .sen_lms1_i  (sen_lms1_i),
      .sen_lms2_i  (sen_lms2_i),
      .sen_dac_i   (sen_dac_i),
      .lms1_miso_i (lms1_miso_i),
      .lms2_miso_i (lms2_miso_i),
      .lms1_sclk_o (lms1_sclk_o),
      .lms1_mosi_o (lms1_mosi_o),
      .lms2_sclk_o (lms2_sclk_o),
      .lms2_mosi_o (lms2_mosi_o),
      .dac_sclk_o  (dac_sclk_o),
      .dac_mosi_o  (dac_mosi_o)
   );

   // Selects go to the devices unchanged
   assign lms1_sen_o = sen_lms1_i;
   assign lms2_sen_o = sen_lms2_i;
   assign dac_sen_o  = sen_dac_i;

endmodule

//--- lms_rx_deinterleave.sv
`timescale 1ns/1ns
`include "lms_frontend_cfg.svh"

module lms_rx_deinterleave
   import lms_frontend_pkg::*;
(
   input  logic         lms_clk,
   input  logic         rst_i,

   input  lms_word_t    rx1_d_i,
   input  logic         rx1_iqsel_i,   // High marks an I word
   input  lms_word_t    rx2_d_i,
   input  logic         rx2_iqsel_i,

   output core_sample_t rx1_i_o,
   output core_sample_t rx1_q_o,
   output logic         rx1_valid_o,
   output core_sample_t rx2_i_o,
   output core_sample_t rx2_q_o,
   output logic         rx2_valid_o
);

   lms_word_t    rx_d [`NUM_LMS];
   logic         rx_iqsel [`NUM_LMS];

   lms_word_t    pend_i [`NUM_LMS];     // Latest I waiting for its Q
   logic         pend_v [`NUM_LMS];
   lms_word_t    pair_q [`NUM_LMS];     // Q that completed a pair
   logic         pair_hit [`NUM_LMS];   // Pair formed on the last edge

   core_sample_t out_i [`NUM_LMS];
   core_sample_t out_q [`NUM_LMS];
   logic         out_v [`NUM_LMS];

   // Channel buses into arrays
   assign rx_d[0]     = rx1_d_i;
   assign rx_d[1]     = rx2_d_i;
   assign rx_iqsel[0] = rx1_iqsel_i;
   assign rx_iqsel[1] = rx2_iqsel_i;

   // Word capture, no reset needed on the data itself
   always_ff @(posedge lms_clk)
   begin
      for (int n = 0; n < `NUM_LMS; n++)
      begin
         if (rx_iqsel[n])
            pend_i[n] <= rx_d[n];         // A repeated I overwrites the older one
         else if (pend_v[n])
            pair_q[n] <= rx_d[n];
      end
   end

   always_ff @(posedge lms_clk)
   begin
      if (rst_i)
      begin
         for (int n = 0; n < `NUM_LMS; n++)
         begin
            pend_v[n]   <= 1'b0;
            pair_hit[n] <= 1'b0;
            out_v[n]    <= 1'b0;
            out_i[n]    <= '0;
            out_q[n]    <= '0;
         end
      end
      else
      begin
         for (int n = 0; n < `NUM_LMS; n++)
         begin
            // A Q word either completes the pair or is an orphan.
            // Both cases leave nothing pending
            pend_v[n]   <= rx_iqsel[n];
            pair_hit[n] <= !rx_iqsel[n] && pend_v[n];
            out_v[n]    <= pair_hit[n];   // One-cycle strobe

            // pend_i still holds the paired I here, since the Q edge left it alone
            if (pair_hit[n])
            begin
               out_i[n] <= lms_to_core(pend_i[n]);
               out_q[n] <= lms_to_core(pair_q[n]);
            end
         end
      end
   end

   assign rx1_i_o     = out_i[0];
   assign rx1_q_o     = out_q[0];
   assign rx1_valid_o = out_v[0];
   assign rx2_i_o     = out_i[1];
   assign rx2_q_o     = out_q[1];
   assign rx2_valid_o = out_v[1];

endmodule

//--- lms_spi_router.sv
`timescale 1ns/1ns

module lms_spi_router
(
   // Shared master
   input  logic spi_sclk_i,
   input  logic spi_mosi_i,
   output logic spi_miso_o,

   // Active-low device selects
   input  logic sen_lms1_i,
   input  logic sen_lms2_i,
   input  logic sen_dac_i,

   input  logic lms1_miso_i,
   input  logic lms2_miso_i,

   output logic lms1_sclk_o,
   output logic lms1_mosi_o,
   output logic lms2_sclk_o,
   output logic lms2_mosi_o,
   output logic dac_sclk_o,
   output logic dac_mosi_o
);

   logic sel_lms1;
   logic sel_lms2;
   logic sel_dac;

   assign sel_lms1 = ~sen_lms1_i;
   assign sel_lms2 = ~sen_lms2_i;
   assign sel_dac  = ~sen_dac_i;

   // Idle devices see a quiet bus
   assign {lms1_sclk_o, lms1_mosi_o} = sel_lms1 ? {spi_sclk_i, spi_mosi_i} : 2'b00;
   assign {lms2_sclk_o, lms2_mosi_o} = sel_lms2 ? {spi_sclk_i, spi_mosi_i} : 2'b00;
   assign {dac_sclk_o, dac_mosi_o}   = sel_dac  ? {spi_sclk_i, spi_mosi_i} : 2'b00;

   // Clock DAC is write only
   assign spi_miso_o = (sel_lms1 & lms1_miso_i) | (sel_lms2 & lms2_miso_i);

endmodule

//--- lms_tx_interleave.sv
`timescale 1ns/1ns
`include "lms_frontend_cfg.svh"

module lms_tx_interleave
   import lms_frontend_pkg::*;
(
   input  logic      lms_clk,
   input  logic      rst_i,

   // Core side, must be stable in the cycle before each load
   input  lms_word_t dac1_i_i,
   input  lms_word_t dac1_q_i,
   input  lms_word_t dac2_i_i,
   input  lms_word_t dac2_q_i,

   output lms_word_t tx1_d_o,
   output lms_word_t tx2_d_o,
   output logic      tx1_iqsel_o,   // Low for I, high for Q
   output logic      tx2_iqsel_o,
   output logic      tx_load_o
);

   lms_word_t dac_i [`NUM_LMS];
   lms_word_t dac_q [`NUM_LMS];
   lms_word_t q_hold [`NUM_LMS];   // Q of the pair in flight
   lms_word_t tx_d [`NUM_LMS];

   logic      phase;               // Zero on the load edge
   logic      iqsel_q;
   logic      load_q;

   assign dac_i[0] = dac1_i_i;
   assign dac_i[1] = dac2_i_i;
   assign dac_q[0] = dac1_q_i;
   assign dac_q[1] = dac2_q_i;

   // Hold Q until the second half of the pair
   always_ff @(posedge lms_clk)
   begin
      for (int n = 0; n < `NUM_LMS; n++)
      begin
         if (!phase)
            q_hold[n] <= dac_q[n];
      end
   end

   always_ff @(posedge lms_clk)
   begin
      if (rst_i)
      begin
         phase   <= 1'b0;
         load_q  <= 1'b0;
         iqsel_q <= 1'b0;
         for (int n = 0; n < `NUM_LMS; n++)
            tx_d[n] <= '0;
      end
      else
      begin
         phase   <= ~phase;
         load_q  <= ~phase;        // Load cycle carries the I word
         iqsel_q <= phase;
         for (int n = 0; n < `NUM_LMS; n++)
         begin
            if (phase)
               tx_d[n] <= q_hold[n];
            else
               tx_d[n] <= dac_i[n];   // I goes straight out on the load edge
         end
      end
   end

   // Both transceivers share one IQ phase
   assign tx1_iqsel_o = iqsel_q;
   assign tx2_iqsel_o = iqsel_q;
   assign tx_load_o   = load_q;
   assign tx1_d_o     = tx_d[0];
   assign tx2_d_o     = tx_d[1];

endmodule

//--- sim.f
+incdir+.
lms_frontend_pkg.sv
lms_rx_deinterleave.sv
lms_tx_interleave.sv
lms_spi_router.sv
lms_frontend_top.sv
lms_frontend_asserts.sv
lms_frontend_checker.sv
lms_frontend_tb.sv
